// File: wakeupPipe_defs.svh
/*
 * Build-time sizes shared by the wakeup pipeline register and its packages.
 * IQ_ENTRIES and ACTIVE_LIST_ENTRIES must be powers of two.
 * Lane-indexed arrays hold the integer lanes first, then the memory lanes.
 */
`ifndef WAKEUP_PIPE_DEFS_SVH
`define WAKEUP_PIPE_DEFS_SVH

`default_nettype none

// Scheduler structure sizes
`define IQ_ENTRIES          16
`define ACTIVE_LIST_ENTRIES 32

// Issue lanes per group
`define INT_ISSUE_WIDTH 2
`define MEM_ISSUE_WIDTH 2
`define ISSUE_WIDTH     (`INT_ISSUE_WIDTH + `MEM_ISSUE_WIDTH)

// Cycles from select to wakeup for each lane group
`define INT_LATENCY 1
`define MEM_LATENCY 3

`default_nettype wire

`endif

// File: recoveryTypesPkg.sv
/*
 * Types that describe a pipeline recovery as seen by the scheduler.
 * A flush range runs from headPtr up to, but not including, tailPtr.
 */
`include "wakeupPipe_defs.svh"

`default_nettype none

package recoveryTypesPkg;

    // Position in the active list
    typedef logic [$clog2(`ACTIVE_LIST_ENTRIES)-1:0] alIndex_t;

    // Ops that a recovery squashes
    typedef struct packed {
        alIndex_t headPtr;
        alIndex_t tailPtr;
        // Overrides the pointer pair and squashes everything
        logic     flushAll;
    } flushRange_t;

    // Recovery request from the recovery manager
    typedef struct packed {
        logic        toRecovery;
        // Set for a selective recovery started at register write
        logic        fromRwStage;
        flushRange_t range;
    } recoveryCmd_t;

endpackage

`default_nettype wire

// File: schedTypesPkg.sv
/*
 * Issue-side types of the wakeup pipeline register.
 * iqOneHot_t serves as both producer vector and issue-queue flush mask.
 */
`include "wakeupPipe_defs.svh"

`default_nettype none

package schedTypesPkg;
    import recoveryTypesPkg::*;

    typedef logic [$clog2(`IQ_ENTRIES)-1:0] iqIndex_t;
    typedef logic [`IQ_ENTRIES-1:0]         iqOneHot_t;

    // One lane's result from the select logic
    typedef struct packed {
        logic      selected;
        iqIndex_t  ptr;
        iqOneHot_t depVector;
        alIndex_t  activeListPtr;
    } laneSelect_t;

    // One stage of an issue lane's latency pipe
    typedef struct packed {
        logic      valid;
        iqIndex_t  ptr;
        iqOneHot_t depVector;
        alIndex_t  activeListPtr;
    } pipeEntry_t;

    // Wakeup of consumers through the producer matrix
    typedef struct packed {
        logic      wakeup;
        iqIndex_t  ptr;
        iqOneHot_t depVector;
    } wakeupOut_t;

    // Issue-queue entry release
    typedef struct packed {
        logic     releaseEntry;
        iqIndex_t ptr;
    } releaseOut_t;

endpackage

`default_nettype wire

// File: selectCapture.sv
/*
 * Converts the select results of all lanes into first-stage pipe entries.
 * Purely combinational. Lane order follows the select array, integer first.
 * An op whose issue-queue entry is flushed in its select cycle enters as a bubble.
 */
`include "wakeupPipe_defs.svh"

`default_nettype none

module selectCapture
    import schedTypesPkg::*;
(
    input  laneSelect_t select [`ISSUE_WIDTH],
    input  iqOneHot_t   flushIqEntry,
    output pipeEntry_t  nextEntry [`ISSUE_WIDTH]
);

    // Lanes whose selected entry is being flushed right now
    logic [`ISSUE_WIDTH-1:0] laneFlushed;

    // Lanes that carry a live op into the pipe
    logic [`ISSUE_WIDTH-1:0] laneLive;

    always_comb begin
        for (int lane = 0; lane < `ISSUE_WIDTH; lane++) begin
            laneFlushed[lane] = flushIqEntry[select[lane].ptr];
            laneLive[lane]    = select[lane].selected && !laneFlushed[lane];
        end
    end

    always_comb begin
        for (int lane = 0; lane < `ISSUE_WIDTH; lane++) begin
            // Payload is copied as is, only valid carries the masking
            nextEntry[lane].valid         = laneLive[lane];
            nextEntry[lane].ptr           = select[lane].ptr;
            nextEntry[lane].depVector     = select[lane].depVector;
            nextEntry[lane].activeListPtr = select[lane].activeListPtr;
        end
    end

endmodule

`default_nettype wire

// File: issueLatencyPipe.sv
/*
 * Delay line of LATENCY stages for a group of LANES issue lanes.
 * Under stall only the first stage holds; with LATENCY above 1 the stage behind
 * it takes a bubble while older stages keep moving.
 * flushWindow stays high while a stage may hold an op older than a selective recovery.
 */
`default_nettype none

module issueLatencyPipe
    import schedTypesPkg::*;
    import recoveryTypesPkg::*;
#(
    parameter int LANES   = 2,
    parameter int LATENCY = 1
) (
    input  logic         clk,
    input  logic         arstN,
    input  logic         stall,
    input  recoveryCmd_t recovery,
    input  pipeEntry_t   nextEntry [LANES],
    output pipeEntry_t   headEntry [LANES],
    output logic         flushWindow
);

    localparam int FIRST_STAGE  = LATENCY - 1;
    localparam int BUBBLE_STAGE = (LATENCY > 1) ? LATENCY - 2 : 0;
    localparam int COUNT_WIDTH  = $clog2(LATENCY) + 1;

    // Stage 0 is the oldest and feeds the outputs
    logic       stageValid [LANES][LATENCY];
    pipeEntry_t stageData  [LANES][LATENCY];

    logic [COUNT_WIDTH-1:0] windowCount;

    logic fullFlush;
    logic selectiveFlush;

    assign fullFlush      = recovery.toRecovery && !recovery.fromRwStage;
    assign selectiveFlush = recovery.toRecovery && recovery.fromRwStage;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int lane = 0; lane < LANES; lane++) begin
                for (int s = 0; s < LATENCY; s++) begin
                    stageValid[lane][s] <= 1'b0;
                end
            end
        end else if (fullFlush) begin
            for (int lane = 0; lane < LANES; lane++) begin
                for (int s = 0; s < LATENCY; s++) begin
                    stageValid[lane][s] <= 1'b0;
                end
            end
        end else if (!stall) begin
            for (int lane = 0; lane < LANES; lane++) begin
                for (int s = 1; s < LATENCY; s++) begin
                    stageValid[lane][s-1] <= stageValid[lane][s];
                end
                stageValid[lane][FIRST_STAGE] <= nextEntry[lane].valid;
            end
        end else begin
            for (int lane = 0; lane < LANES; lane++) begin
                for (int s = 1; s < LATENCY - 1; s++) begin
                    stageValid[lane][s-1] <= stageValid[lane][s];
                end
                if (LATENCY > 1) begin
                    stageValid[lane][BUBBLE_STAGE] <= 1'b0;
                end
            end
        end
    end

    // Payload follows the same movement as the valid bits
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < LANES; lane++) begin
            for (int s = 1; s < LATENCY - 1; s++) begin
                stageData[lane][s-1] <= stageData[lane][s];
            end
            if (!stall) begin
                if (LATENCY > 1) begin
                    stageData[lane][BUBBLE_STAGE] <= stageData[lane][FIRST_STAGE];
                end
                stageData[lane][FIRST_STAGE] <= nextEntry[lane];
            end else if (LATENCY > 1) begin
                stageData[lane][BUBBLE_STAGE].depVector <= '0;
            end
        end
    end

    always_comb begin
        for (int lane = 0; lane < LANES; lane++) begin
            headEntry[lane]       = stageData[lane][0];
            headEntry[lane].valid = stageValid[lane][0];
        end
    end

    // Counts the stages that may still hold a squashed op
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            windowCount <= '0;
        end else if (selectiveFlush) begin
            windowCount <= COUNT_WIDTH'(LATENCY);
        end else if (windowCount == COUNT_WIDTH'(LATENCY)) begin
            // First stage is frozen by stall
            if (!stall) begin
                windowCount <= windowCount - 1'b1;
            end
        end else if (windowCount != '0) begin
            windowCount <= windowCount - 1'b1;
        end
    end

    assign flushWindow = (windowCount != '0);

endmodule

`default_nettype wire

// File: selectiveFlushFilter.sv
/*
 * Output side of the wakeup pipeline register.
 * Holds the last selective flush range and suppresses wakeup of squashed ops.
 * Release is never suppressed, so a squashed op still frees its issue-queue entry.
 * Stall gates the integer lanes only.
 */
`include "wakeupPipe_defs.svh"

`default_nettype none

module selectiveFlushFilter
    import schedTypesPkg::*;
    import recoveryTypesPkg::*;
(
    input  logic         clk,
    input  logic         arstN,
    input  logic         stall,
    input  recoveryCmd_t recovery,
    input  pipeEntry_t   intHead [`INT_ISSUE_WIDTH],
    input  pipeEntry_t   memHead [`MEM_ISSUE_WIDTH],
    input  logic         intFlushWindow,
    input  logic         memFlushWindow,
    output wakeupOut_t   wakeupOut [`ISSUE_WIDTH],
    output releaseOut_t  releaseOut [`ISSUE_WIDTH],
    output logic         flushedOpExist
);

    flushRange_t rangeQ;

    logic [`INT_ISSUE_WIDTH-1:0] intFlushed;
    logic [`MEM_ISSUE_WIDTH-1:0] memFlushed;

    // Circular test on the active list, empty when head equals tail
    function automatic logic inFlushRange(flushRange_t r, alIndex_t ptr);
        logic aboveHead;
        logic belowTail;
        aboveHead = (ptr >= r.headPtr);
        belowTail = (ptr < r.tailPtr);
        if (r.flushAll) begin
            return 1'b1;
        end
        if (r.headPtr <= r.tailPtr) begin
            return aboveHead && belowTail;
        end
        return aboveHead || belowTail;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rangeQ <= '0;
        end else if (recovery.toRecovery && recovery.fromRwStage) begin
            rangeQ <= recovery.range;
        end
    end

    always_comb begin
        for (int lane = 0; lane < `INT_ISSUE_WIDTH; lane++) begin
            intFlushed[lane] = intFlushWindow
                && inFlushRange(rangeQ, intHead[lane].activeListPtr);
            wakeupOut[lane].wakeup    = intHead[lane].valid && !intFlushed[lane] && !stall;
            wakeupOut[lane].ptr       = intHead[lane].ptr;
            wakeupOut[lane].depVector = stall ? '0 : intHead[lane].depVector;
            releaseOut[lane].releaseEntry = intHead[lane].valid && !stall;
            releaseOut[lane].ptr          = intHead[lane].ptr;
        end
        // Memory lanes sit after the integer lanes
        for (int lane = 0; lane < `MEM_ISSUE_WIDTH; lane++) begin
            memFlushed[lane] = memFlushWindow
                && inFlushRange(rangeQ, memHead[lane].activeListPtr);
            wakeupOut[`INT_ISSUE_WIDTH+lane].wakeup    = memHead[lane].valid && !memFlushed[lane];
            wakeupOut[`INT_ISSUE_WIDTH+lane].ptr       = memHead[lane].ptr;
            wakeupOut[`INT_ISSUE_WIDTH+lane].depVector = memHead[lane].depVector;
            releaseOut[`INT_ISSUE_WIDTH+lane].releaseEntry = memHead[lane].valid;
            releaseOut[`INT_ISSUE_WIDTH+lane].ptr          = memHead[lane].ptr;
        end
    end

    assign flushedOpExist = intFlushWindow || memFlushWindow;

endmodule

`default_nettype wire

// File: wakeupPipelineRegister.sv
/*
 * Wakeup pipeline register of the out-of-order scheduler.
 * Integer ops wake consumers one edge after select, memory ops three edges after.
 * Stall is the only back-pressure and there is no handshake.
 */
`include "wakeupPipe_defs.svh"

`default_nettype none

module wakeupPipelineRegister
    import schedTypesPkg::*;
    import recoveryTypesPkg::*;
(
    input  logic         clk,
    input  logic         arstN,
    input  logic         stall,
    input  laneSelect_t  select [`ISSUE_WIDTH],
    input  iqOneHot_t    flushIqEntry,
    input  recoveryCmd_t recovery,
    output wakeupOut_t   wakeupOut [`ISSUE_WIDTH],
    output releaseOut_t  releaseOut [`ISSUE_WIDTH],
    output logic         flushedOpExist
);

    pipeEntry_t nextEntry [`ISSUE_WIDTH];
    pipeEntry_t intHead   [`INT_ISSUE_WIDTH];
    pipeEntry_t memHead   [`MEM_ISSUE_WIDTH];
    logic       intFlushWindow;
    logic       memFlushWindow;

    selectCapture capture (
        .select       (select),
        .flushIqEntry (flushIqEntry),
        .nextEntry    (nextEntry)
    );

    issueLatencyPipe #(
        .LANES   (`INT_ISSUE_WIDTH),
        .LATENCY (`INT_LATENCY)
    ) intPipe (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .recovery    (recovery),
        .nextEntry   (nextEntry[0:`INT_ISSUE_WIDTH-1]),
        .headEntry   (intHead),
        .flushWindow (intFlushWindow)
    );

    issueLatencyPipe #(
        .LANES   (`MEM_ISSUE_WIDTH),
        .LATENCY (`MEM_LATENCY)
    ) memPipe (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .recovery    (recovery),
        .nextEntry   (nextEntry[`INT_ISSUE_WIDTH:`ISSUE_WIDTH-1]),
        .headEntry   (memHead),
        .flushWindow (memFlushWindow)
    );

    selectiveFlushFilter flushFilter (
        .clk            (clk),
        .arstN          (arstN),
        .stall          (stall),
        .recovery       (recovery),
        .intHead        (intHead),
        .memHead        (memHead),
        .intFlushWindow (intFlushWindow),
        .memFlushWindow (memFlushWindow),
        .wakeupOut      (wakeupOut),
        .releaseOut     (releaseOut),
        .flushedOpExist (flushedOpExist)
    );

endmodule

`default_nettype wire

// File: wakeupPipe_props.sv
/*
 * Concurrent checks bound into the wakeup pipeline register.
 * The flush-window check only applies when no stall and no new selective
 * recovery occur in the three cycles after a selective recovery.
 */
`include "wakeupPipe_defs.svh"

`default_nettype none

module wakeupPipeProps
    import schedTypesPkg::*;
    import recoveryTypesPkg::*;
(
    input  logic         clk,
    input  logic         arstN,
    input  logic         stall,
    input  recoveryCmd_t recovery,
    input  wakeupOut_t   wakeupOut [`ISSUE_WIDTH],
    input  releaseOut_t  releaseOut [`ISSUE_WIDTH],
    input  logic         flushedOpExist
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`ISSUE_WIDTH-1:0] wakeBits;
    logic [`ISSUE_WIDTH-1:0] releaseBits;
    logic                    selectiveRecovery;

    // Number of failed assertions
    int assertFailures = 0;

    always_comb begin
        for (int lane = 0; lane < `ISSUE_WIDTH; lane++) begin
            wakeBits[lane]    = wakeupOut[lane].wakeup;
            releaseBits[lane] = releaseOut[lane].releaseEntry;
        end
    end

    assign selectiveRecovery = recovery.toRecovery && recovery.fromRwStage;

    quietInReset: assert property (@(posedge clk)
        !arstN |-> (wakeBits == '0 && releaseBits == '0 && !flushedOpExist))
        else begin
            $error("Wakeup, release or flushedOpExist active during reset");
            assertFailures++;
        end

    // Integer lanes are the low lane indices
    intWakeupStalled: assert property (@(posedge clk) disable iff (!arstN)
        stall |-> (wakeBits[`INT_ISSUE_WIDTH-1:0] == '0))
        else begin
            $error("Integer wakeup asserted while stalled");
            assertFailures++;
        end

    wakeupNeedsRelease: assert property (@(posedge clk) disable iff (!arstN)
        (wakeBits & ~releaseBits) == '0)
        else begin
            $error("Wakeup without release on the same lane");
            assertFailures++;
        end

    windowCloses: assert property (@(posedge clk) disable iff (!arstN)
        selectiveRecovery ##1 (!stall && !selectiveRecovery) [*3] |=> !flushedOpExist)
        else begin
            $error("flushedOpExist still high three stall-free cycles after recovery");
            assertFailures++;
        end

endmodule

bind wakeupPipelineRegister wakeupPipeProps props (
    .clk            (clk),
    .arstN          (arstN),
    .stall          (stall),
    .recovery       (recovery),
    .wakeupOut      (wakeupOut),
    .releaseOut     (releaseOut),
    .flushedOpExist (flushedOpExist)
);

`default_nettype wire

// File: wakeupPipe_tb.sv
/*
 * Self-checking testbench for the wakeup pipeline register.
 * A shadow model of stages, flush-window counters and the latched range predicts
 * every output on each rising edge. Payload fields are checked only where defined.
 */
`include "wakeupPipe_defs.svh"

`default_nettype none

module wakeupPipe_tb
    import schedTypesPkg::*;
    import recoveryTypesPkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    // Reset, about 60 directed and 400 random cycles, plus margin
    localparam int MAX_CYCLES    = 700;
    localparam int RANDOM_CYCLES = 400;

    logic         clk = 1'b0;
    logic         arstN;
    logic         stall;
    laneSelect_t  select [`ISSUE_WIDTH];
    iqOneHot_t    flushIqEntry;
    recoveryCmd_t recovery;
    wakeupOut_t   wakeupOut [`ISSUE_WIDTH];
    releaseOut_t  releaseOut [`ISSUE_WIDTH];
    logic         flushedOpExist;

    // Shadow model, stage 0 is the oldest
    pipeEntry_t  modelStage [`ISSUE_WIDTH][`MEM_LATENCY];
    int          modelCount [2];
    flushRange_t modelRange;

    integer seed;
    int     cycleCount = 0;
    int     wakeupErrors = 0;
    int     releaseErrors = 0;
    int     statusErrors = 0;

    wakeupPipelineRegister i_dut (
        .clk            (clk),
        .arstN          (arstN),
        .stall          (stall),
        .select         (select),
        .flushIqEntry   (flushIqEntry),
        .recovery       (recovery),
        .wakeupOut      (wakeupOut),
        .releaseOut     (releaseOut),
        .flushedOpExist (flushedOpExist)
    );

    always #50 clk = ~clk;

    function automatic int laneLatency(input int lane);
        return (lane < `INT_ISSUE_WIDTH) ? `INT_LATENCY : `MEM_LATENCY;
    endfunction

    // Forward distance from headPtr decides membership in the range
    function automatic logic insideSquashRange(input flushRange_t r, input alIndex_t ptr);
        alIndex_t distPtr;
        alIndex_t distTail;
        distPtr  = ptr - r.headPtr;
        distTail = r.tailPtr - r.headPtr;
        return r.flushAll || (distPtr < distTail);
    endfunction

    function automatic void expectOutputs(input int lane, input logic stallNow,
            output wakeupOut_t expWake, output releaseOut_t expRel);
        pipeEntry_t head;
        logic       window;
        logic       squashed;
        logic       gated;
        head     = modelStage[lane][0];
        window   = (lane < `INT_ISSUE_WIDTH) ? (modelCount[0] != 0) : (modelCount[1] != 0);
        squashed = window && head.valid && insideSquashRange(modelRange, head.activeListPtr);
        gated    = (lane < `INT_ISSUE_WIDTH) && stallNow;
        expWake.wakeup      = head.valid && !squashed && !gated;
        expWake.ptr         = head.ptr;
        expWake.depVector   = gated ? '0 : head.depVector;
        expRel.releaseEntry = head.valid && !gated;
        expRel.ptr          = head.ptr;
    endfunction

    task automatic compareWakeup(input int lane, input wakeupOut_t actual,
            input wakeupOut_t expected, input logic depDefined);
        logic bad;
        bad = (actual.wakeup !== expected.wakeup);
        if (expected.wakeup && actual.ptr !== expected.ptr) begin
            bad = 1'b1;
        end
        if ((expected.wakeup || depDefined) && actual.depVector !== expected.depVector) begin
            bad = 1'b1;
        end
        if (bad) begin
            wakeupErrors++;
            $display("CHECK FAILED at %0t: wakeup lane %0d got %b/%h/%h, expected %b/%h/%h",
                $time, lane, actual.wakeup, actual.ptr, actual.depVector,
                expected.wakeup, expected.ptr, expected.depVector);
        end
    endtask

    task automatic compareRelease(input int lane, input releaseOut_t actual,
            input releaseOut_t expected);
        if (actual.releaseEntry !== expected.releaseEntry
                || (expected.releaseEntry && actual.ptr !== expected.ptr)) begin
            releaseErrors++;
            $display("CHECK FAILED at %0t: release lane %0d got %b/%h, expected %b/%h",
                $time, lane, actual.releaseEntry, actual.ptr,
                expected.releaseEntry, expected.ptr);
        end
    endtask

    task automatic compareStatus(input logic actual, input logic expected);
        if (actual !== expected) begin
            statusErrors++;
            $display("CHECK FAILED at %0t: flushedOpExist got %b, expected %b",
                $time, actual, expected);
        end
    endtask

    task automatic clearModel();
        for (int lane = 0; lane < `ISSUE_WIDTH; lane++) begin
            for (int s = 0; s < `MEM_LATENCY; s++) begin
                modelStage[lane][s] = '0;
            end
        end
        modelCount[0] = 0;
        modelCount[1] = 0;
        modelRange    = '0;
    endtask

    // Advances the shadow model by one rising edge
    task automatic updateModel();
        pipeEntry_t incoming;
        int         lat;
        logic       fullRec;
        logic       selRec;
        fullRec = recovery.toRecovery && !recovery.fromRwStage;
        selRec  = recovery.toRecovery && recovery.fromRwStage;
        for (int lane = 0; lane < `ISSUE_WIDTH; lane++) begin
            lat = laneLatency(lane);
            incoming.valid         = select[lane].selected && !flushIqEntry[select[lane].ptr];
            incoming.ptr           = select[lane].ptr;
            incoming.depVector     = select[lane].depVector;
            incoming.activeListPtr = select[lane].activeListPtr;
            if (fullRec) begin
                for (int s = 0; s < lat; s++) begin
                    modelStage[lane][s].valid = 1'b0;
                end
            end else if (!stall) begin
                for (int s = 1; s < lat; s++) begin
                    modelStage[lane][s-1] = modelStage[lane][s];
                end
                modelStage[lane][lat-1] = incoming;
            end else if (lat > 1) begin
                // Youngest stage holds, the one behind it gets a bubble
                for (int s = 1; s < lat - 1; s++) begin
                    modelStage[lane][s-1] = modelStage[lane][s];
                end
                modelStage[lane][lat-2].valid = 1'b0;
            end
        end
        for (int g = 0; g < 2; g++) begin
            lat = (g == 0) ? `INT_LATENCY : `MEM_LATENCY;
            if (selRec) begin
                modelCount[g] = lat;
            end else if (modelCount[g] == lat) begin
                if (!stall) begin
                    modelCount[g]--;
                end
            end else if (modelCount[g] > 0) begin
                modelCount[g]--;
            end
        end
        if (selRec) begin
            modelRange = recovery.range;
        end
    endtask

    // Outputs are stable here since the falling edge
    always @(posedge clk) begin
        wakeupOut_t  expWake;
        releaseOut_t expRel;
        for (int lane = 0; lane < `ISSUE_WIDTH; lane++) begin
            expectOutputs(lane, stall, expWake, expRel);
            compareWakeup(lane, wakeupOut[lane], expWake, (lane < `INT_ISSUE_WIDTH) && stall);
            compareRelease(lane, releaseOut[lane], expRel);
        end
        compareStatus(flushedOpExist, (modelCount[0] != 0) || (modelCount[1] != 0));
        if (!arstN) begin
            clearModel();
        end else begin
            updateModel();
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles because the stimulus did not finish",
                cycleCount);
            $display("Errors: wakeup %0d, release %0d, status %0d, assertion %0d",
                wakeupErrors, releaseErrors, statusErrors, i_dut.props.assertFailures);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic clearInputs();
        for (int lane = 0; lane < `ISSUE_WIDTH; lane++) begin
            select[lane] = '0;
        end
        flushIqEntry = '0;
        recovery     = '0;
        stall        = 1'b0;
    endtask

    task automatic nextCycle();
        @(negedge clk);
        clearInputs();
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            nextCycle();
        end
    endtask

    task automatic setOp(input int lane, input iqIndex_t ptr, input iqOneHot_t dep,
            input alIndex_t alPtr);
        select[lane].selected      = 1'b1;
        select[lane].ptr           = ptr;
        select[lane].depVector     = dep;
        select[lane].activeListPtr = alPtr;
    endtask

    task automatic setSelective(input alIndex_t headPtr, input alIndex_t tailPtr,
            input logic flushAll);
        recovery.toRecovery     = 1'b1;
        recovery.fromRwStage    = 1'b1;
        recovery.range.headPtr  = headPtr;
        recovery.range.tailPtr  = tailPtr;
        recovery.range.flushAll = flushAll;
    endtask

    task automatic driveRandomCycle();
        logic [31:0] roll;
        nextCycle();
        for (int lane = 0; lane < `ISSUE_WIDTH; lane++) begin
            roll = $random(seed);
            select[lane].selected      = (roll[1:0] != 2'b00);
            select[lane].ptr           = roll[5:2];
            select[lane].activeListPtr = roll[10:6];
            roll = $random(seed);
            select[lane].depVector     = roll[15:0];
        end
        roll = $random(seed);
        if (roll[1:0] == 2'b00) begin
            flushIqEntry = roll[31:16] & roll[15:0];
        end
        roll = $random(seed);
        stall = (roll[2:0] == 3'b000);
        if (roll[6:3] == 4'd0) begin
            recovery.toRecovery = 1'b1;
        end else if (roll[6:3] == 4'd1) begin
            setSelective(roll[11:7], roll[16:12], roll[19:17] == 3'b000);
        end
    endtask

    initial begin
        seed  = 51;
        arstN = 1'b1;
        clearInputs();
        clearModel();
        #10;
        arstN = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        // Latency of one and three edges
        nextCycle();
        setOp(0, 4'h3, 16'h0101, 5'd1);
        setOp(2, 4'h7, 16'h8000, 5'd2);
        idleCycles(4);

        // Ops whose entries are flushed in the select cycle
        nextCycle();
        setOp(1, 4'h5, 16'h00f0, 5'd3);
        setOp(3, 4'h9, 16'h0f00, 5'd4);
        flushIqEntry = 16'h0220;
        idleCycles(4);

        // Stall holds the first stage and drops a memory bubble
        nextCycle();
        setOp(2, 4'h1, 16'h0002, 5'd5);
        nextCycle();
        setOp(0, 4'h2, 16'h0004, 5'd6);
        setOp(3, 4'h4, 16'h0010, 5'd7);
        nextCycle();
        stall = 1'b1;
        setOp(1, 4'h6, 16'h0040, 5'd8);
        nextCycle();
        stall = 1'b1;
        idleCycles(5);

        // Full recovery empties every stage
        nextCycle();
        setOp(2, 4'ha, 16'h1000, 5'd9);
        setOp(3, 4'hb, 16'h2000, 5'd10);
        nextCycle();
        setOp(0, 4'hc, 16'h4000, 5'd11);
        nextCycle();
        recovery.toRecovery = 1'b1;
        idleCycles(4);

        // Selective recovery with a plain, a wrapping and a flushAll range
        for (int pass = 0; pass < 3; pass++) begin
            nextCycle();
            setOp(2, 4'hd, 16'h0003, (pass == 1) ? 5'd31 : 5'd10);
            setOp(3, 4'he, 16'h000c, 5'd20);
            nextCycle();
            setOp(0, 4'hf, 16'h0030, (pass == 1) ? 5'd1 : 5'd11);
            setOp(1, 4'h8, 16'h00c0, 5'd25);
            if (pass == 0) begin
                setSelective(5'd8, 5'd16, 1'b0);
            end else begin
                setSelective(5'd30, 5'd3, pass == 2);
            end
            idleCycles(5);
        end

        // Mixed traffic
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            driveRandomCycle();
        end
        idleCycles(6);

        $display("Errors: wakeup %0d, release %0d, status %0d, assertion %0d",
            wakeupErrors, releaseErrors, statusErrors, i_dut.props.assertFailures);
        if (wakeupErrors + releaseErrors + statusErrors + i_dut.props.assertFailures == 0)
        begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
recoveryTypesPkg.sv
schedTypesPkg.sv
selectCapture.sv
issueLatencyPipe.sv
selectiveFlushFilter.sv
wakeupPipelineRegister.sv
wakeupPipe_props.sv
wakeupPipe_tb.sv
